// ==== all.f ====
+incdir+verilog
verilog/cx4_map_pkg.sv
verilog/cx4_dma_pkg.sv
verilog/cx4_datram.sv
verilog/cx4_dma.sv
verilog/cx4_host_regs.sv
verilog/cx4.sv
verification/cx4_checker.sv
verification/tb_cx4.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cx4
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_cx4.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module tb_cx4;

  import cx4_map_pkg::*;
  import cx4_dma_pkg::*;

  // 3 transfers x 64 bytes x 7 cycles, plus about 600 for reads
  localparam int         TIMEOUT_CYCLES = 4000;
  localparam host_addr_t STATUS_ADDR    = {`CX4_MMIO_PAGE, `CX4_STATUS_BASE};

  logic       CLK;
  logic       rst_n;
  logic       cs;
  logic       reg_we_rising;
  host_addr_t addr;
  host_byte_t din;
  host_byte_t dout;
  host_byte_t bus_di  = 8'h00;
  logic       bus_rdy = 1'b0;
  bus_addr_t  bus_addr;
  logic       bus_rrq;
  logic       cx4_active;
  logic       rd_chk;
  logic       done;
  int         errors;
  int         cycles;
  int         seed;
  int         len;
  int         tgt_i;
  logic [31:0] rnd;
  host_addr_t  ram_a;
  logic [4:0]  off;
  logic [1:0]  delays [64];     // bus wait per low address bits
  logic [1:0]  wait_cnt;
  logic        bus_pend;

  cx4 u_cx4 (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cs            (cs),
    .reg_we_rising (reg_we_rising),
    .addr          (addr),
    .din           (din),
    .dout          (dout),
    .bus_di        (bus_di),
    .bus_addr      (bus_addr),
    .bus_rrq       (bus_rrq),
    .bus_rdy       (bus_rdy),
    .cx4_active    (cx4_active)
  );

  cx4_checker u_checker (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cs            (cs),
    .reg_we_rising (reg_we_rising),
    .addr          (addr),
    .din           (din),
    .dout          (dout),
    .bus_addr      (bus_addr),
    .bus_rrq       (bus_rrq),
    .bus_rdy       (bus_rdy),
    .cx4_active    (cx4_active),
    .rd_chk        (rd_chk),
    .done          (done),
    .errors        (errors)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////
  // bus memory model
  ////////////////////////////////
  always @(posedge CLK) begin
    if (!rst_n) begin
      bus_rdy  <= 1'b0;
      bus_pend <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      bus_rdy <= 1'b0;
      if (bus_rrq) begin
        bus_pend <= 1'b1;
        wait_cnt <= delays[bus_addr[5:0]];
      end else if (bus_pend) begin
        if (wait_cnt == 2'd0) begin
          bus_rdy  <= 1'b1;                   // one cycle only
          bus_di   <= bus_addr[7:0] ^ bus_addr[15:8] ^ bus_addr[23:16];
          bus_pend <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end
    end
  end

  function automatic host_addr_t reg_addr(input logic [4:0] o);
    return {`CX4_MMIO_PAGE, o};
  endfunction

  task automatic host_write(input host_addr_t a, input host_byte_t d);
    @(posedge CLK);
    addr          <= a;
    din           <= d;
    cs            <= 1'b1;
    reg_we_rising <= 1'b1;
    @(posedge CLK);
    reg_we_rising <= 1'b0;
  endtask

  // checker compares dout on the edge after this task returns
  task automatic host_read(input host_addr_t a);
    @(posedge CLK);
    addr   <= a;
    cs     <= 1'b1;
    rd_chk <= 1'b1;
    @(posedge CLK);
    rd_chk <= 1'b0;
  endtask

  task automatic run_transfer(input bus_addr_t src, input int n, input int tgt);
    host_addr_t a;
    logic [4:0] o;
    foreach (delays[i]) begin
      rnd       = $random(seed);
      delays[i] = rnd[1:0];
    end
    host_write(reg_addr(REG_DMASRC_L), src[7:0]);
    host_write(reg_addr(REG_DMASRC_M), src[15:8]);
    host_write(reg_addr(REG_DMASRC_H), src[23:16]);
    host_write(reg_addr(REG_DMALEN_L), n[7:0]);
    host_write(reg_addr(REG_DMALEN_H), n[15:8]);
    host_write(reg_addr(REG_DMATGT_L), tgt[7:0]);
    host_write(reg_addr(REG_DMATGT_M), {4'h0, tgt[11:8]});
    host_write(reg_addr(REG_DMATGT_H), 8'h00);   // kicks the engine
    @(posedge CLK);
    while (!bus_rrq) @(posedge CLK);
    if (n >= 4) begin
      host_read(STATUS_ADDR);                 // busy status mid transfer
    end
    while (cx4_active) @(posedge CLK);
    host_read(STATUS_ADDR);
    o = 5'h00;
    repeat (8) begin
      host_read(reg_addr(o));
      o = o + 1'b1;
    end
    a = {1'b0, tgt[11:0]};
    repeat (n) begin
      host_read(a);
      a = a + 1'b1;
    end
  endtask

  ////////////////////////////////
  // stimulus
  ////////////////////////////////
  initial begin
    CLK           = 1'b0;
    rst_n         = 1'b0;
    cs            = 1'b0;
    reg_we_rising = 1'b0;
    addr          = '0;
    din           = '0;
    rd_chk        = 1'b0;
    done          = 1'b0;
    seed          = 32'h31207304;
    foreach (delays[i]) delays[i] = 2'd0;
    repeat (5) @(posedge CLK);
    rst_n <= 1'b1;
    host_read(STATUS_ADDR);                   // idle after reset
    host_read(13'h0C00);                      // no window
    repeat (4) begin
      rnd   = $random(seed);
      ram_a = {1'b0, rnd[11:0] % `CX4_DATRAM_SIZE};
      host_write(ram_a, rnd[23:16]);
      host_read(ram_a);
    end
    off = 5'h08;
    repeat (11) begin                         // offsets 0x08 to 0x12
      host_read(reg_addr(off));
      off = off + 1'b1;
    end
    repeat (3) begin
      rnd   = $random(seed);
      len   = {26'h0, rnd[5:0]} + 1;
      rnd   = $random(seed);
      tgt_i = {20'h0, rnd[11:0]} % (int'(`CX4_DATRAM_SIZE) - len);
      rnd   = $random(seed);
      run_transfer(rnd[23:0], len, tgt_i);
    end
    repeat (3) @(posedge CLK);
    done <= 1'b1;
    repeat (2) @(posedge CLK);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/cx4_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module cx4_checker (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire                     cs,
  input  wire                     reg_we_rising,
  input  cx4_map_pkg::host_addr_t addr,
  input  cx4_map_pkg::host_byte_t din,
  input  cx4_map_pkg::host_byte_t dout,
  input  cx4_dma_pkg::bus_addr_t  bus_addr,
  input  wire                     bus_rrq,
  input  wire                     bus_rdy,
  input  wire                     cx4_active,
  input  wire                     rd_chk,
  input  wire                     done,
  output int                      errors
);

  import cx4_map_pkg::*;
  import cx4_dma_pkg::*;

  host_byte_t   regs [8];                     // dma register bytes
  host_byte_t   ram_m [`CX4_DATRAM_SIZE];     // expected data ram
  bus_addr_t    src_ptr;
  datram_addr_t tgt_ptr;
  int           xfer_len;
  int           rrq_cnt;
  int           reads;
  int           requests;
  logic         busy_m;                       // transfer running in the model
  logic         rrq_q;
  logic         act_q;
  logic         rst_q;
  logic         pend;
  logic         reported;
  host_addr_t   pend_addr;
  host_byte_t   pend_exp;

  // byte the bus memory holds at an address
  function automatic host_byte_t bus_byte(input bus_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16];
  endfunction

  function automatic bus_addr_t map_src(input bus_addr_t a);
    return {1'b0, a[23:16], a[14:0]};  // bit 15 of the source is skipped
  endfunction

  function automatic host_byte_t expect_read(input host_addr_t a);
    host_byte_t v;
    v = 8'h00;                                // outside every window
    if (a[11:0] < `CX4_DATRAM_SIZE) begin
      v = ram_m[a[11:0]];
    end else if (a[12:5] == `CX4_MMIO_PAGE) begin
      if (a[4:0] < 5'h08) begin
        v = regs[a[2:0]];
      end else if (a[4:0] < `CX4_STATUS_BASE) begin
        v = 8'hFF;                            // dropped offsets
      end else begin
        v[`CX4_ST_ACTIVE_BIT] = busy_m;
        v[`CX4_ST_IDLE_BIT]   = ~busy_m;
      end
    end
    return v;
  endfunction

  ////////////////////////////////
  // model and compare
  ////////////////////////////////
  always @(posedge CLK) begin
    if (!rst_n) begin
      busy_m   = 1'b0;
      pend     = 1'b0;
      rrq_q    = 1'b0;
      act_q    = 1'b0;
      reported = 1'b0;
      foreach (regs[i]) regs[i] = 8'h00;
    end else begin
      if (!rst_q && (cx4_active !== 1'b0 || bus_rrq !== 1'b0)) begin
        $display("engine is not idle after reset");
        errors++;
      end
      if (pend) begin                         // read issued two edges back
        reads++;
        if (dout !== pend_exp) begin
          $display("MISMATCH dout addr %h expected %h got %h", pend_addr, pend_exp, dout);
          errors++;
        end
      end
      pend      = rd_chk;
      pend_addr = addr;
      pend_exp  = expect_read(addr);
      if (cs && reg_we_rising) begin
        if (addr[11:0] < `CX4_DATRAM_SIZE) begin
          ram_m[addr[11:0]] = din;
        end else if (addr[12:5] == `CX4_MMIO_PAGE && addr[4:0] < 5'h08) begin
          regs[addr[2:0]] = din;
          if (addr[4:0] == REG_DMATGT_H) begin  // engine start
            src_ptr  = {regs[2], regs[1], regs[0]};
            tgt_ptr  = {regs[6][3:0], regs[5]};
            xfer_len = {16'h0000, regs[4], regs[3]};
            rrq_cnt  = 0;
            busy_m   = 1'b1;
          end
        end
      end
      if (bus_rrq) begin
        requests++;
        if (rrq_q) begin
          $display("bus_rrq stayed high for two cycles");
          errors++;
        end
        if (!busy_m) begin
          $display("bus request seen with no transfer running");
          errors++;
        end
        if (bus_addr !== map_src(src_ptr)) begin
          $display("MISMATCH bus_addr expected %h got %h", map_src(src_ptr), bus_addr);
          errors++;
        end
        if (cx4_active !== 1'b1) begin
          $display("MISMATCH cx4_active expected %h got %h", 1'b1, cx4_active);
          errors++;
        end
        ram_m[tgt_ptr] = bus_byte(map_src(src_ptr));
        src_ptr        = src_ptr + 1'b1;
        tgt_ptr        = tgt_ptr + 1'b1;
        rrq_cnt++;
      end
      if (bus_rdy && busy_m && rrq_cnt == xfer_len) begin
        busy_m = 1'b0;                        // last byte handed over
      end
      if (act_q && !cx4_active && rrq_cnt != xfer_len) begin
        $display("MISMATCH bus_rrq pulses expected %h got %h", xfer_len, rrq_cnt);
        errors++;
      end
      rrq_q = bus_rrq;
      act_q = cx4_active;
      if (done && !reported) begin
        reported = 1'b1;
        $display("checker: %0d errors, %0d reads compared, %0d bus requests",
                 errors, reads, requests);
      end
    end
    rst_q = rst_n;
  end

endmodule

`default_nettype wire

// ==== verilog/cx4.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module cx4 (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire                     cs,
  input  wire                     reg_we_rising,
  input  cx4_map_pkg::host_addr_t addr,
  input  cx4_map_pkg::host_byte_t din,
  output cx4_map_pkg::host_byte_t dout,
  input  cx4_map_pkg::host_byte_t bus_di,
  output cx4_dma_pkg::bus_addr_t  bus_addr,
  output logic                    bus_rrq,
  input  wire                     bus_rdy,
  output logic                    cx4_active
);

  import cx4_map_pkg::*;
  import cx4_dma_pkg::*;

  logic         host_ram_we;
  host_byte_t   host_ram_rdata;
  logic         dma_start;
  bus_addr_t    dma_src;
  dma_len_t     dma_len;
  bus_addr_t    dma_tgt;
  datram_addr_t dma_ram_addr;
  host_byte_t   dma_ram_wdata;
  logic         dma_ram_we;

  cx4_host_regs u_host_regs (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cs            (cs),
    .reg_we_rising (reg_we_rising),
    .addr          (addr),
    .din           (din),
    .dma_active    (cx4_active),
    .ram_rdata     (host_ram_rdata),
    .dout          (dout),
    .ram_we        (host_ram_we),
    .dma_start     (dma_start),
    .dma_src       (dma_src),
    .dma_len       (dma_len),
    .dma_tgt       (dma_tgt)
  );

  cx4_dma u_dma (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dma_start (dma_start),
    .dma_src   (dma_src),
    .dma_len   (dma_len),
    .dma_tgt   (dma_tgt),
    .bus_rdy   (bus_rdy),
    .bus_di    (bus_di),
    .bus_addr  (bus_addr),
    .bus_rrq   (bus_rrq),
    .active    (cx4_active),
    .ram_addr  (dma_ram_addr),
    .ram_wdata (dma_ram_wdata),
    .ram_we    (dma_ram_we)
  );

  cx4_datram u_datram (
    .CLK     (CLK),
    .a_addr  (addr[`CX4_DATRAM_AW-1:0]),   // host window offset
    .a_we    (host_ram_we),
    .a_wdata (din),
    .b_addr  (dma_ram_addr),
    .b_we    (dma_ram_we),
    .b_wdata (dma_ram_wdata),
    .a_rdata (host_ram_rdata),
    .b_rdata ()                          // no reader on this side
  );

endmodule

`default_nettype wire

// ==== verilog/cx4_host_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module cx4_host_regs (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire                     cs,
  input  wire                     reg_we_rising,
  input  cx4_map_pkg::host_addr_t addr,
  input  cx4_map_pkg::host_byte_t din,
  input  wire                     dma_active,
  input  cx4_map_pkg::host_byte_t ram_rdata,
  output cx4_map_pkg::host_byte_t dout,
  output logic                    ram_we,
  output logic                    dma_start,
  output cx4_dma_pkg::bus_addr_t  dma_src,
  output cx4_dma_pkg::dma_len_t   dma_len,
  output cx4_dma_pkg::bus_addr_t  dma_tgt
);

  import cx4_map_pkg::*;

  window_e    win;
  mmio_reg_e  reg_off;
  logic       page_hit;
  logic       mmio_we;
  host_byte_t mmio_q;     // registered register read
  host_byte_t status;

  ////////////////////////////////
  // window decode
  ////////////////////////////////
  assign page_hit = (addr[12:5] == `CX4_MMIO_PAGE);
  assign reg_off  = mmio_reg_e'(addr[4:0]);

  always_comb begin
    if (cs && (addr[`CX4_DATRAM_AW-1:0] < `CX4_DATRAM_SIZE)) begin
      win = WIN_DATRAM;
    end else if (cs && page_hit) begin
      win = (addr[4:0] < `CX4_STATUS_BASE) ? WIN_MMIO : WIN_STATUS;
    end else begin
      win = WIN_NONE;
    end
  end

  assign ram_we  = reg_we_rising && (win == WIN_DATRAM);
  assign mmio_we = reg_we_rising && (win == WIN_MMIO);

  ////////////////////////////////
  // dma register file
  ////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dma_src <= '0;
      dma_len <= '0;
      dma_tgt <= '0;
    end else if (mmio_we) begin
      case (reg_off)
        REG_DMASRC_L: dma_src[7:0]   <= din;
        REG_DMASRC_M: dma_src[15:8]  <= din;
        REG_DMASRC_H: dma_src[23:16] <= din;
        REG_DMALEN_L: dma_len[7:0]   <= din;
        REG_DMALEN_H: dma_len[15:8]  <= din;
        REG_DMATGT_L: dma_tgt[7:0]   <= din;
        REG_DMATGT_M: dma_tgt[15:8]  <= din;
        REG_DMATGT_H: dma_tgt[23:16] <= din;
        default: ;                           // dropped offsets ignore writes
      endcase
    end
  end

  // pulse follows the high target byte write
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dma_start <= 1'b0;
    end else begin
      dma_start <= mmio_we && (reg_off == REG_DMATGT_H);
    end
  end

  ////////////////////////////////
  // read path
  ////////////////////////////////
  always_ff @(posedge CLK) begin
    case (reg_off)
      REG_DMASRC_L: mmio_q <= dma_src[7:0];
      REG_DMASRC_M: mmio_q <= dma_src[15:8];
      REG_DMASRC_H: mmio_q <= dma_src[23:16];
      REG_DMALEN_L: mmio_q <= dma_len[7:0];
      REG_DMALEN_H: mmio_q <= dma_len[15:8];
      REG_DMATGT_L: mmio_q <= dma_tgt[7:0];
      REG_DMATGT_M: mmio_q <= dma_tgt[15:8];
      REG_DMATGT_H: mmio_q <= dma_tgt[23:16];
      default:      mmio_q <= 8'hFF;          // undecoded offset
    endcase
  end

  always_comb begin
    status                     = '0;
    status[`CX4_ST_ACTIVE_BIT] = dma_active;
    status[`CX4_ST_IDLE_BIT]   = ~dma_active;
  end

  always_comb begin
    case (win)
      WIN_DATRAM: dout = ram_rdata;
      WIN_MMIO:   dout = mmio_q;
      WIN_STATUS: dout = status;       // not registered
      default:    dout = 8'h00;
    endcase
  end

  a_start_single : assert property (@(posedge CLK) disable iff (!rst_n)
    dma_start |=> !dma_start)
    else $error("dma_start held for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/cx4_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module cx4_dma (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire                       dma_start,
  input  cx4_dma_pkg::bus_addr_t    dma_src,
  input  cx4_dma_pkg::dma_len_t     dma_len,
  input  cx4_dma_pkg::bus_addr_t    dma_tgt,
  input  wire                       bus_rdy,
  input  wire [`CX4_DATA_W-1:0]     bus_di,
  output cx4_dma_pkg::bus_addr_t    bus_addr,
  output logic                      bus_rrq,
  output logic                      active,
  output cx4_dma_pkg::datram_addr_t ram_addr,
  output logic [`CX4_DATA_W-1:0]    ram_wdata,
  output logic                      ram_we
);

  import cx4_dma_pkg::*;

  dma_state_e state;
  bus_addr_t  src_q;    // current source byte
  dma_len_t   count;    // bytes still to fetch

  // bank byte over the low 15 bits, top bit unused
  assign bus_addr = {1'b0, src_q[23:16], src_q[14:0]};

  ////////////////////////////////
  // transfer fsm
  ////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= DMA_IDLE;
      active   <= 1'b0;
      bus_rrq  <= 1'b0;
      ram_we   <= 1'b0;
      src_q    <= '0;
      ram_addr <= '0;
      count    <= '0;
    end else begin
      case (state)
        DMA_IDLE: begin
          if (dma_start) state <= DMA_START;
        end
        DMA_START: begin
          active   <= 1'b1;
          src_q    <= dma_src;
          ram_addr <= dma_tgt[`CX4_DATRAM_AW-1:0];
          count    <= dma_len;                  // zero wraps to 64k
          bus_rrq  <= 1'b1;
          state    <= DMA_WAIT;
        end
        DMA_WAIT: begin
          bus_rrq <= 1'b0;
          if (!bus_rrq && bus_rdy) begin        // rdy ignored in the pulse cycle
            ram_we <= 1'b1;
            count  <= count - 1'b1;
            state  <= DMA_ADDR;
          end
        end
        DMA_ADDR: begin
          ram_we   <= 1'b0;
          src_q    <= src_q + 1'b1;
          ram_addr <= ram_addr + 1'b1;
          if (count == '0) begin
            active <= 1'b0;
            state  <= DMA_IDLE;
          end else begin
            bus_rrq <= 1'b1;                    // next byte
            state   <= DMA_WAIT;
          end
        end
        default: state <= DMA_IDLE;
      endcase
    end
  end

  // bus byte is only valid with rdy, hold it for the write
  always_ff @(posedge CLK) begin
    if (state == DMA_WAIT && !bus_rrq && bus_rdy) begin
      ram_wdata <= bus_di;
    end
  end

  a_rrq_pulse : assert property (@(posedge CLK) disable iff (!rst_n)
    bus_rrq |=> !bus_rrq)
    else $error("bus_rrq high for two cycles");

  a_we_active : assert property (@(posedge CLK) disable iff (!rst_n)
    ram_we |-> active)
    else $error("port b write outside a transfer");

endmodule

`default_nettype wire

// ==== verilog/cx4_datram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cx4_params.svh"

module cx4_datram (
  input  wire                       CLK,
  input  cx4_dma_pkg::datram_addr_t a_addr,
  input  wire                       a_we,
  input  wire [`CX4_DATA_W-1:0]     a_wdata,
  input  cx4_dma_pkg::datram_addr_t b_addr,
  input  wire                       b_we,
  input  wire [`CX4_DATA_W-1:0]     b_wdata,
  output logic [`CX4_DATA_W-1:0]    a_rdata,
  output logic [`CX4_DATA_W-1:0]    b_rdata
);

  logic [`CX4_DATA_W-1:0] mem [`CX4_DATRAM_SIZE];

  ////////////////////////////////
  // both ports, read before write
  ////////////////////////////////
  always_ff @(posedge CLK) begin
    a_rdata <= mem[a_addr];
    b_rdata <= mem[b_addr];
    if (a_we) begin
      mem[a_addr] <= a_wdata;   // host side
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;   // dma side
    end
  end

  // same byte from both ports at once is left undefined

endmodule

`default_nettype wire

// ==== verilog/cx4_dma_pkg.sv ====
`default_nettype none

`include "cx4_params.svh"

package cx4_dma_pkg;

  typedef logic [`CX4_BUS_AW-1:0]    bus_addr_t;
  typedef logic [`CX4_DMA_LEN_W-1:0] dma_len_t;
  typedef logic [`CX4_DATRAM_AW-1:0] datram_addr_t;

  // one-hot transfer states
  typedef enum logic [3:0] {
    DMA_IDLE  = 4'b0001,
    DMA_START = 4'b0010,
    DMA_WAIT  = 4'b0100,
    DMA_ADDR  = 4'b1000
  } dma_state_e;

endpackage

`default_nettype wire

// ==== verilog/cx4_map_pkg.sv ====
`default_nettype none

`include "cx4_params.svh"

package cx4_map_pkg;

  typedef logic [`CX4_HOST_AW-1:0] host_addr_t;
  typedef logic [`CX4_DATA_W-1:0]  host_byte_t;

  // register block offsets, the rest read 0xff
  typedef enum logic [4:0] {
    REG_DMASRC_L = 5'h00,
    REG_DMASRC_M = 5'h01,
    REG_DMASRC_H = 5'h02,
    REG_DMALEN_L = 5'h03,
    REG_DMALEN_H = 5'h04,
    REG_DMATGT_L = 5'h05,
    REG_DMATGT_M = 5'h06,
    REG_DMATGT_H = 5'h07  // write starts dma
  } mmio_reg_e;

  typedef enum logic [1:0] {
    WIN_NONE   = 2'd0,
    WIN_DATRAM = 2'd1,
    WIN_MMIO   = 2'd2,
    WIN_STATUS = 2'd3
  } window_e;

endpackage

`default_nettype wire

// ==== verilog/cx4_params.svh ====
`ifndef CX4_PARAMS_SVH
`define CX4_PARAMS_SVH

////////////////////////////////
// widths
////////////////////////////////
`define CX4_DATA_W        8      // one host or bus byte
`define CX4_HOST_AW       13     // host window address
`define CX4_BUS_AW        24     // external bus address
`define CX4_DMA_LEN_W     16     // transfer byte count
`define CX4_DATRAM_AW     12     // data ram address

////////////////////////////////
// map and status
////////////////////////////////
`define CX4_DATRAM_SIZE   12'hC00 // data ram bytes
`define CX4_MMIO_PAGE     8'hFA   // addr[12:5] of register block
`define CX4_STATUS_BASE   5'h13   // first status offset
`define CX4_ST_ACTIVE_BIT 6       // engine running
`define CX4_ST_IDLE_BIT   1       // engine stopped

`endif
